//--- Bender.yml
package:
  name: hdc_csr

sources:
  - source/csr_pkg.sv
  - source/csr_bus_port.sv
  - source/csr_reg_file.sv
  - source/csr_read_mux.sv
  - source/csr_obs_fsm.sv
  - source/csr_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_csr.sv

//--- source/csr_bus_port.sv
/*
  Request and response side of the register bus.
  Requests are always accepted and split into write and read strobes.
  Read data passes straight through when the master takes it at once,
  otherwise it is parked in a holding register until the response is taken.
*/
`timescale 1ns/1ns

module csr_bus_port (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  csr_pkg::csr_req_t                req_i,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  logic [csr_pkg::CsrDataWidth-1:0] rd_data_i,
  output logic [csr_pkg::CsrDataWidth-1:0] rsp_data_o,
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i,
  output logic                             wr_en_o,
  output logic                             rd_en_o
);

  logic                             req_fire;
  logic                             rsp_fire;
  logic                             held_q;
  logic [csr_pkg::CsrDataWidth-1:0] held_data_q;

  assign req_ready_o = 1'b1;
  assign req_fire    = req_valid_i & req_ready_o;
  assign wr_en_o     = req_fire & req_i.write;
  assign rd_en_o     = req_fire & ~req_i.write;
  assign rsp_fire    = rsp_valid_o & rsp_ready_i;

  // Holding flag for a response the master did not take
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
    end else if (rd_en_o && !rsp_fire) begin
      held_q <= 1'b1;
    end else if (rsp_fire) begin
      held_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_o && !rsp_fire) begin
      held_data_q <= rd_data_i;
    end
  end

  assign rsp_valid_o = rd_en_o | held_q;
  assign rsp_data_o  = held_q ? held_data_q : rd_data_i;

endmodule

//--- source/csr_obs_fsm.sv
/*
  Summary of the core state for the observable register.
  Tracks idle, debug, running and done from the start and clear pulses,
  the core busy flag and the instruction debug mode bit.
*/
`timescale 1ns/1ns

module csr_obs_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  logic                clr_i,
  input  logic                busy_i,
  input  logic                dbg_i,
  output csr_pkg::obs_state_e state_o
);

  csr_pkg::obs_state_e state_q;
  csr_pkg::obs_state_e state_d;

  // First matching condition wins
  always_comb begin
    state_d = state_q;
    if (start_i) begin
      state_d = csr_pkg::OBS_RUNNING;
    end else if ((state_q == csr_pkg::OBS_RUNNING) && !busy_i) begin
      state_d = csr_pkg::OBS_DONE;
    end else if ((state_q == csr_pkg::OBS_IDLE) && dbg_i) begin
      state_d = csr_pkg::OBS_DEBUG;
    end else if (clr_i) begin
      state_d = csr_pkg::OBS_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= csr_pkg::OBS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

//--- source/csr_pkg.sv
/*
  Shared definitions for the accelerator control and status registers.
  Holds bus widths, register word addresses, field bit positions, the
  observable state encoding and the structs that carry requests, pulses
  and configuration between the blocks. Referenced by scoped names only.
*/
package csr_pkg;

  // --------------------
  // Widths and sizes
  // --------------------
  localparam int unsigned CsrDataWidth       = 32;
  localparam int unsigned CsrAddrWidth       = 32;
  localparam int unsigned InstMemAddrWidth   = 8;
  localparam int unsigned InstLoopCountWidth = 16;
  localparam int unsigned NumLoops           = 4;
  localparam int unsigned NumRegs            = 13;
  localparam int unsigned ObsWidth           = 4;

  // Core settings register fields
  localparam int unsigned CoreStartBit    = 0;
  localparam int unsigned CoreBusyBit     = 1;
  localparam int unsigned CoreSeqTestBit  = 2;
  localparam int unsigned CorePortALsb    = 3;
  localparam int unsigned CorePortBBit    = 5;
  localparam int unsigned CoreClrBit      = 6;
  localparam int unsigned CoreFifoClrBit  = 7;
  localparam int unsigned CoreRegsClrBit  = 8;
  localparam int unsigned CoreDslcClrBit  = 9;

  // Instruction control and prediction fields
  localparam int unsigned InstWriteModeBit = 0;
  localparam int unsigned InstDbgBit       = 1;
  localparam int unsigned InstClrBit       = 2;
  localparam int unsigned PredValidBit     = 8;

  // --------------------
  // Register word addresses
  // --------------------
  typedef enum logic [CsrAddrWidth-1:0] {
    CORE_SET     = 0,
    AM_NUM_PRED  = 1,
    AM_PRED      = 2,
    INST_CTRL    = 3,
    INST_WR_ADDR = 4,
    INST_WR_DATA = 5,
    INST_PC      = 6,
    LOOP_CTRL    = 7,
    LOOP_JUMP    = 8,
    LOOP_END     = 9,
    LOOP_COUNT1  = 10,
    LOOP_COUNT2  = 11,
    OBSERVABLE   = 12
  } csr_addr_e;

  typedef enum logic [1:0] {
    OBS_IDLE    = 2'b00,
    OBS_RUNNING = 2'b01,
    OBS_DEBUG   = 2'b10,
    OBS_DONE    = 2'b11
  } obs_state_e;

  // --------------------
  // Structs
  // --------------------
  typedef struct packed {
    logic [CsrAddrWidth-1:0] addr;
    logic [CsrDataWidth-1:0] data;
    logic                    write;
  } csr_req_t;

  typedef struct packed {
    logic start;
    logic clr;
    logic fifo_clr;
    logic regs_clr;
    logic dslc_clr;
    logic inst_clr;
    logic pred_valid_clr;
  } ctrl_pulse_t;

  typedef struct packed {
    logic                    seq_test;
    logic [1:0]              port_a_sel;
    logic                    port_b_sel;
    logic [CsrDataWidth-1:0] am_num_pred;
    logic                    inst_write_mode;
    logic                    inst_dbg;
  } core_cfg_t;

  typedef struct packed {
    logic [2:0]                                   mode;
    logic [1:0]                                   hvdim_sel;
    logic [4:0]                                   ext_count;
    logic                                         ext_en;
    logic [NumLoops-1:0][InstMemAddrWidth-1:0]    jump_addr;
    logic [NumLoops-1:0][InstMemAddrWidth-1:0]    end_addr;
    logic [NumLoops-1:0][InstLoopCountWidth-1:0]  count;
  } loop_cfg_t;

  typedef struct packed {
    logic [InstMemAddrWidth-1:0] addr;
    logic                        addr_en;
    logic [CsrDataWidth-1:0]     data;
    logic                        data_en;
  } inst_wr_t;

endpackage

//--- source/csr_read_mux.sv
/*
  Read data assembly.
  Builds the word returned for a read address from stored registers and
  live status inputs. Write-only bits and unmapped addresses read as zero.
*/
`timescale 1ns/1ns

module csr_read_mux (
  input  logic [csr_pkg::CsrAddrWidth-1:0]                        addr_i,
  input  logic [csr_pkg::NumRegs-1:0][csr_pkg::CsrDataWidth-1:0]  regs_i,
  input  logic                                                    busy_i,
  input  logic [7:0]                                              am_pred_i,
  input  logic                                                    am_pred_valid_i,
  input  logic [csr_pkg::InstMemAddrWidth-1:0]                    inst_pc_i,
  input  csr_pkg::obs_state_e                                     obs_state_i,
  output logic [csr_pkg::CsrDataWidth-1:0]                        rd_data_o
);

  always_comb begin
    rd_data_o = '0;
    case (addr_i)
      csr_pkg::CORE_SET: begin
        rd_data_o[csr_pkg::CorePortBBit]        =
          regs_i[csr_pkg::CORE_SET][csr_pkg::CorePortBBit];
        rd_data_o[csr_pkg::CorePortALsb +: 2]   =
          regs_i[csr_pkg::CORE_SET][csr_pkg::CorePortALsb +: 2];
        rd_data_o[csr_pkg::CoreSeqTestBit]      =
          regs_i[csr_pkg::CORE_SET][csr_pkg::CoreSeqTestBit];
        rd_data_o[csr_pkg::CoreBusyBit]         = busy_i;
      end
      csr_pkg::AM_PRED: begin
        rd_data_o[csr_pkg::PredValidBit] = am_pred_valid_i;
        rd_data_o[7:0]                   = am_pred_i;
      end
      csr_pkg::INST_CTRL: begin
        // Clear bit is write-only
        rd_data_o[csr_pkg::InstWriteModeBit] =
          regs_i[csr_pkg::INST_CTRL][csr_pkg::InstWriteModeBit];
        rd_data_o[csr_pkg::InstDbgBit]       =
          regs_i[csr_pkg::INST_CTRL][csr_pkg::InstDbgBit];
      end
      csr_pkg::INST_PC: begin
        rd_data_o[csr_pkg::InstMemAddrWidth-1:0] = inst_pc_i;
      end
      csr_pkg::LOOP_CTRL: begin
        rd_data_o[9:0] = regs_i[csr_pkg::LOOP_CTRL][9:0];
      end
      csr_pkg::OBSERVABLE: begin
        rd_data_o[3:2] = obs_state_i;
        rd_data_o[1:0] = regs_i[csr_pkg::OBSERVABLE][1:0];
      end
      csr_pkg::AM_NUM_PRED,
      csr_pkg::LOOP_JUMP,
      csr_pkg::LOOP_END,
      csr_pkg::LOOP_COUNT1,
      csr_pkg::LOOP_COUNT2: begin
        rd_data_o = regs_i[addr_i[3:0]];
      end
      default: begin
        rd_data_o = '0;
      end
    endcase
  end

endmodule

//--- source/csr_reg_file.sv
/*
  Register storage with write decode.
  Stores the writable words, turns write-only bits into single-cycle pulses
  and instruction-memory write strobes, and unpacks the stored fields into
  the configuration structs that drive the accelerator core.
*/
`timescale 1ns/1ns

module csr_reg_file (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    wr_en_i,
  input  csr_pkg::csr_req_t                                       req_i,
  output logic [csr_pkg::NumRegs-1:0][csr_pkg::CsrDataWidth-1:0]  regs_o,
  output csr_pkg::ctrl_pulse_t                                    pulse_o,
  output csr_pkg::core_cfg_t                                      core_cfg_o,
  output csr_pkg::loop_cfg_t                                      loop_cfg_o,
  output csr_pkg::inst_wr_t                                       inst_wr_o
);

  logic [csr_pkg::NumRegs-1:0][csr_pkg::CsrDataWidth-1:0] regs_q;
  logic store_en;
  logic wr_core;
  logic wr_inst;

  // Read-only words and the instruction write ports hold no storage
  assign store_en = wr_en_i && (req_i.addr < csr_pkg::NumRegs) &&
                    (req_i.addr != csr_pkg::AM_PRED) &&
                    (req_i.addr != csr_pkg::INST_PC) &&
                    (req_i.addr != csr_pkg::INST_WR_ADDR) &&
                    (req_i.addr != csr_pkg::INST_WR_DATA);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '0;
    end else begin
      for (int i = 0; i < csr_pkg::NumRegs; i++) begin
        if (store_en && (req_i.addr == i)) begin
          regs_q[i] <= req_i.data;
        end
      end
    end
  end

  assign regs_o = regs_q;

  // --------------------
  // Write-only pulses
  // --------------------
  assign wr_core = wr_en_i && (req_i.addr == csr_pkg::CORE_SET);
  assign wr_inst = wr_en_i && (req_i.addr == csr_pkg::INST_CTRL);

  always_comb begin
    pulse_o.start          = wr_core && req_i.data[csr_pkg::CoreStartBit];
    pulse_o.clr            = wr_core && req_i.data[csr_pkg::CoreClrBit];
    pulse_o.fifo_clr       = wr_core && req_i.data[csr_pkg::CoreFifoClrBit];
    pulse_o.regs_clr       = wr_core && req_i.data[csr_pkg::CoreRegsClrBit];
    pulse_o.dslc_clr       = wr_core && req_i.data[csr_pkg::CoreDslcClrBit];
    pulse_o.inst_clr       = wr_inst && req_i.data[csr_pkg::InstClrBit];
    pulse_o.pred_valid_clr = wr_en_i && (req_i.addr == csr_pkg::AM_PRED) &&
                             req_i.data[csr_pkg::PredValidBit];
  end

  // Instruction memory write port, straight from the request
  always_comb begin
    inst_wr_o.addr    = req_i.data[csr_pkg::InstMemAddrWidth-1:0];
    inst_wr_o.addr_en = wr_en_i && (req_i.addr == csr_pkg::INST_WR_ADDR);
    inst_wr_o.data    = req_i.data;
    inst_wr_o.data_en = wr_en_i && (req_i.addr == csr_pkg::INST_WR_DATA);
  end

  // --------------------
  // Configuration fields
  // --------------------
  always_comb begin
    core_cfg_o.seq_test        = regs_q[csr_pkg::CORE_SET][csr_pkg::CoreSeqTestBit];
    core_cfg_o.port_a_sel      = regs_q[csr_pkg::CORE_SET][csr_pkg::CorePortALsb +: 2];
    core_cfg_o.port_b_sel      = regs_q[csr_pkg::CORE_SET][csr_pkg::CorePortBBit];
    core_cfg_o.am_num_pred     = regs_q[csr_pkg::AM_NUM_PRED];
    core_cfg_o.inst_write_mode = regs_q[csr_pkg::INST_CTRL][csr_pkg::InstWriteModeBit];
    core_cfg_o.inst_dbg        = regs_q[csr_pkg::INST_CTRL][csr_pkg::InstDbgBit];
  end

  always_comb begin
    // Loop control word is mode 2:0, dimension select 4:3, extension count 9:5
    loop_cfg_o.mode      = regs_q[csr_pkg::LOOP_CTRL][2:0];
    loop_cfg_o.hvdim_sel = regs_q[csr_pkg::LOOP_CTRL][4:3];
    loop_cfg_o.ext_count = regs_q[csr_pkg::LOOP_CTRL][9:5];
    loop_cfg_o.ext_en    = |regs_q[csr_pkg::LOOP_CTRL][9:5];
    for (int i = 0; i < csr_pkg::NumLoops; i++) begin
      loop_cfg_o.jump_addr[i] =
        regs_q[csr_pkg::LOOP_JUMP][i*csr_pkg::InstMemAddrWidth +: csr_pkg::InstMemAddrWidth];
      loop_cfg_o.end_addr[i]  =
        regs_q[csr_pkg::LOOP_END][i*csr_pkg::InstMemAddrWidth +: csr_pkg::InstMemAddrWidth];
      // Two counts per word, lower loop in the low half
      loop_cfg_o.count[i] = regs_q[csr_pkg::LOOP_COUNT1 + i/2]
                                  [(i%2)*csr_pkg::InstLoopCountWidth +:
                                   csr_pkg::InstLoopCountWidth];
    end
  end

endmodule

//--- source/csr_top.sv
/*
  Control and status register block of the HDC accelerator.
  Connects the bus port, register file, read mux and observable FSM.
  Reads answer in the accept cycle; writes land on the next clock edge.
*/
`timescale 1ns/1ns

module csr_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Request and response
  input  csr_pkg::csr_req_t                    req_i,
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  output logic [csr_pkg::CsrDataWidth-1:0]     rsp_data_o,
  output logic                                 rsp_valid_o,
  input  logic                                 rsp_ready_i,
  // Core status
  input  logic                                 busy_i,
  input  logic [7:0]                           am_pred_i,
  input  logic                                 am_pred_valid_i,
  input  logic [csr_pkg::InstMemAddrWidth-1:0] inst_pc_i,
  // Configuration and control
  output csr_pkg::ctrl_pulse_t                 pulse_o,
  output csr_pkg::core_cfg_t                   core_cfg_o,
  output csr_pkg::loop_cfg_t                   loop_cfg_o,
  output csr_pkg::inst_wr_t                    inst_wr_o,
  output logic [csr_pkg::ObsWidth-1:0]         obs_o
);

  logic                                                   wr_en;
  logic [csr_pkg::CsrDataWidth-1:0]                       rd_data;
  logic [csr_pkg::NumRegs-1:0][csr_pkg::CsrDataWidth-1:0] regs;
  csr_pkg::obs_state_e                                    obs_state;

  csr_bus_port u_bus_port (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rd_data_i   (rd_data),
    .rsp_data_o  (rsp_data_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .wr_en_o     (wr_en),
    .rd_en_o     ()
  );

  csr_reg_file u_reg_file (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_en_i    (wr_en),
    .req_i      (req_i),
    .regs_o     (regs),
    .pulse_o    (pulse_o),
    .core_cfg_o (core_cfg_o),
    .loop_cfg_o (loop_cfg_o),
    .inst_wr_o  (inst_wr_o)
  );

  csr_read_mux u_read_mux (
    .addr_i          (req_i.addr),
    .regs_i          (regs),
    .busy_i          (busy_i),
    .am_pred_i       (am_pred_i),
    .am_pred_valid_i (am_pred_valid_i),
    .inst_pc_i       (inst_pc_i),
    .obs_state_i     (obs_state),
    .rd_data_o       (rd_data)
  );

  csr_obs_fsm u_obs_fsm (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (pulse_o.start),
    .clr_i   (pulse_o.clr),
    .busy_i  (busy_i),
    .dbg_i   (core_cfg_o.inst_dbg),
    .state_o (obs_state)
  );

  // State on top, software-owned bits below
  assign obs_o = {obs_state, regs[csr_pkg::OBSERVABLE][1:0]};

endmodule

//--- sources.f
+incdir+verification
source/csr_pkg.sv
source/csr_bus_port.sv
source/csr_reg_file.sv
source/csr_read_mux.sv
source/csr_obs_fsm.sv
source/csr_top.sv
verification/tb_csr.sv

//--- verification/tb_csr_table.svh
/*
  Stimulus table for the CSR testbench.
  Each entry is one operation with address, data, status input values,
  a mask over the shadow copy of the register and the expected bits.
  A read expects (shadow & mask) | exp; a state wait expects obs_o == exp.
*/
`ifndef TB_CSR_TABLE_SVH
`define TB_CSR_TABLE_SVH

typedef enum logic [2:0] {
  OP_WR,
  OP_WR_RAND,
  OP_RD,
  OP_RD_HOLD,
  OP_STATUS,
  OP_WAIT_OBS,
  OP_CFG
} op_e;

// Status is {busy, pred_valid, pred[7:0], pc[7:0]}
typedef struct packed {
  op_e         op;
  logic [31:0] addr;
  logic [31:0] data;
  logic [17:0] stat;
  logic [31:0] mask;
  logic [31:0] exp;
} entry_t;

entry_t tbl[$];

task automatic append_entry(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                            input logic [17:0] stat, input logic [31:0] mask,
                            input logic [31:0] exp);
  entry_t e;
  e.op   = op;
  e.addr = addr;
  e.data = data;
  e.stat = stat;
  e.mask = mask;
  e.exp  = exp;
  tbl.push_back(e);
endtask

task automatic load_table();
  // Configuration outputs with all fields still zero
  append_entry(OP_CFG, 0, 0, 0, 0, 0);
  // Random writes and readback
  append_entry(OP_WR_RAND, csr_pkg::AM_NUM_PRED, 0, 0, 0, 0);
  append_entry(OP_RD, csr_pkg::AM_NUM_PRED, 0, 0, 32'hFFFF_FFFF, 0);
  append_entry(OP_WR_RAND, csr_pkg::LOOP_JUMP, 0, 0, 0, 0);
  append_entry(OP_RD, csr_pkg::LOOP_JUMP, 0, 0, 32'hFFFF_FFFF, 0);
  append_entry(OP_WR_RAND, csr_pkg::LOOP_END, 0, 0, 0, 0);
  append_entry(OP_RD, csr_pkg::LOOP_END, 0, 0, 32'hFFFF_FFFF, 0);
  append_entry(OP_WR_RAND, csr_pkg::LOOP_COUNT1, 0, 0, 0, 0);
  append_entry(OP_RD, csr_pkg::LOOP_COUNT1, 0, 0, 32'hFFFF_FFFF, 0);
  append_entry(OP_WR_RAND, csr_pkg::LOOP_COUNT2, 0, 0, 0, 0);
  append_entry(OP_RD, csr_pkg::LOOP_COUNT2, 0, 0, 32'hFFFF_FFFF, 0);
  append_entry(OP_WR_RAND, csr_pkg::LOOP_CTRL, 0, 0, 0, 0);
  append_entry(OP_RD, csr_pkg::LOOP_CTRL, 0, 0, 32'h0000_03FF, 0);
  append_entry(OP_WR_RAND, csr_pkg::INST_CTRL, 0, 0, 0, 0);
  append_entry(OP_RD, csr_pkg::INST_CTRL, 0, 0, 32'h0000_0003, 0);
  append_entry(OP_WR_RAND, csr_pkg::CORE_SET, 0, 0, 0, 0);
  append_entry(OP_RD, csr_pkg::CORE_SET, 0, 0, 32'h0000_003C, 0);
  append_entry(OP_CFG, 0, 0, 0, 0, 0);
  // Back-pressured response
  append_entry(OP_RD_HOLD, csr_pkg::LOOP_END, 0, 0, 32'hFFFF_FFFF, 0);
  // Pulses and instruction write ports
  append_entry(OP_WR, csr_pkg::CORE_SET, 32'h0000_03C1, 0, 0, 0);
  append_entry(OP_WR, csr_pkg::INST_CTRL, 32'h0000_0004, 0, 0, 0);
  append_entry(OP_WR, csr_pkg::AM_PRED, 32'h0000_0100, 0, 0, 0);
  append_entry(OP_WR, csr_pkg::INST_WR_ADDR, 32'h0000_00A5, 0, 0, 0);
  append_entry(OP_WR, csr_pkg::INST_WR_DATA, 32'hDEAD_BEEF, 0, 0, 0);
  append_entry(OP_CFG, 0, 0, 0, 0, 0);
  // Read-only sources
  append_entry(OP_STATUS, 0, 0, 18'h33C5A, 0, 0);
  append_entry(OP_RD, csr_pkg::CORE_SET, 0, 0, 32'h0000_003C, 32'h0000_0002);
  append_entry(OP_RD, csr_pkg::AM_PRED, 0, 0, 0, 32'h0000_013C);
  append_entry(OP_RD, csr_pkg::INST_PC, 0, 0, 0, 32'h0000_005A);
  append_entry(OP_WR, csr_pkg::AM_PRED, 32'hFFFF_FEFF, 0, 0, 0);
  append_entry(OP_WR, csr_pkg::INST_PC, 32'hFFFF_FFFF, 0, 0, 0);
  append_entry(OP_RD, csr_pkg::AM_PRED, 0, 0, 0, 32'h0000_013C);
  append_entry(OP_RD, csr_pkg::INST_PC, 0, 0, 0, 32'h0000_005A);
  append_entry(OP_WR, 32'd20, 32'h1234_5678, 0, 0, 0);
  append_entry(OP_RD, 32'd20, 0, 0, 0, 0);
  // Observable state sequence, software bits 1:0 set to 01
  append_entry(OP_WR, csr_pkg::OBSERVABLE, 32'hFFFF_FFFD, 0, 0, 0);
  append_entry(OP_STATUS, 0, 0, 18'h00000, 0, 0);
  append_entry(OP_WR, csr_pkg::CORE_SET, 32'h0000_0040, 0, 0, 0);
  append_entry(OP_WAIT_OBS, 0, 0, 0, 0, 32'h1);
  append_entry(OP_RD, csr_pkg::OBSERVABLE, 0, 0, 32'h3, 32'h0);
  append_entry(OP_WR, csr_pkg::INST_CTRL, 32'h0000_0002, 0, 0, 0);
  append_entry(OP_WAIT_OBS, 0, 0, 0, 0, 32'h9);
  append_entry(OP_RD, csr_pkg::OBSERVABLE, 0, 0, 32'h3, 32'h8);
  append_entry(OP_STATUS, 0, 0, 18'h20000, 0, 0);
  append_entry(OP_WR, csr_pkg::CORE_SET, 32'h0000_0001, 0, 0, 0);
  append_entry(OP_WAIT_OBS, 0, 0, 0, 0, 32'h5);
  append_entry(OP_RD, csr_pkg::OBSERVABLE, 0, 0, 32'h3, 32'h4);
  append_entry(OP_STATUS, 0, 0, 18'h00000, 0, 0);
  append_entry(OP_WAIT_OBS, 0, 0, 0, 0, 32'hD);
  append_entry(OP_RD, csr_pkg::OBSERVABLE, 0, 0, 32'h3, 32'hC);
  append_entry(OP_WR, csr_pkg::INST_CTRL, 32'h0000_0000, 0, 0, 0);
  append_entry(OP_WR, csr_pkg::CORE_SET, 32'h0000_0040, 0, 0, 0);
  append_entry(OP_WAIT_OBS, 0, 0, 0, 0, 32'h1);
  append_entry(OP_RD, csr_pkg::OBSERVABLE, 0, 0, 32'h3, 32'h0);
endtask

`endif

//--- verification/tb_csr.sv
/*
  Testbench for the CSR block.
  Checks the reset state, then applies the stimulus table in order and
  compares reads, pulses, configuration outputs and the observable state
  against a shadow copy of the writable registers.
*/
`timescale 1ns/1ns

module tb_csr;

  localparam int Timeout = 20;

  logic                  clk_i;
  logic                  rst_ni;
  csr_pkg::csr_req_t     req_i;
  logic                  req_valid_i;
  logic                  req_ready_o;
  logic [31:0]           rsp_data_o;
  logic                  rsp_valid_o;
  logic                  rsp_ready_i;
  logic                  busy_i;
  logic [7:0]            am_pred_i;
  logic                  am_pred_valid_i;
  logic [7:0]            inst_pc_i;
  csr_pkg::ctrl_pulse_t  pulse_o;
  csr_pkg::core_cfg_t    core_cfg_o;
  csr_pkg::loop_cfg_t    loop_cfg_o;
  csr_pkg::inst_wr_t     inst_wr_o;
  logic [3:0]            obs_o;

  logic [31:0] shadow [13];
  logic [15:0] lfsr_q;

  `include "tb_csr_table.svh"

  csr_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic compare_values(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w = {w[30:0], lfsr_q[0]};
    end
  endtask

  // Expected {addr_en, data_en, start, clr, fifo, regs, slicer, inst, pred}
  function automatic logic [8:0] pulse_model(input logic [31:0] a, input logic [31:0] d);
    logic [8:0] p;
    p = '0;
    if (a == 0) begin
      p[6] = d[0];
      p[5] = d[6];
      p[4] = d[7];
      p[3] = d[8];
      p[2] = d[9];
    end
    if (a == 3) p[1] = d[2];
    if (a == 2) p[0] = d[8];
    p[8] = (a == 4);
    p[7] = (a == 5);
    return p;
  endfunction

  function automatic logic [31:0] shadow_word(input logic [31:0] a);
    return (a < 13) ? shadow[a] : 32'h0;
  endfunction

  // --------------------
  // Bus operations
  // --------------------
  task automatic do_write(input logic [31:0] wr_addr, input logic [31:0] wr_data);
    logic [8:0] exp_p;
    exp_p = pulse_model(wr_addr, wr_data);
    @(posedge clk_i);
    req_i.addr  <= wr_addr;
    req_i.data  <= wr_data;
    req_i.write <= 1'b1;
    req_valid_i <= 1'b1;
    @(negedge clk_i);
    compare_values("req_ready_o", req_ready_o, 1);
    compare_values("pulse_o", pulse_o, exp_p[6:0]);
    compare_values("inst_wr_o.addr_en", inst_wr_o.addr_en, exp_p[8]);
    compare_values("inst_wr_o.data_en", inst_wr_o.data_en, exp_p[7]);
    if (exp_p[8]) compare_values("inst_wr_o.addr", inst_wr_o.addr, wr_data[7:0]);
    if (exp_p[7]) compare_values("inst_wr_o.data", inst_wr_o.data, wr_data);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    @(negedge clk_i);
    compare_values("pulse_o", pulse_o, 0);
    compare_values("inst_wr_o.addr_en", inst_wr_o.addr_en, 0);
    compare_values("inst_wr_o.data_en", inst_wr_o.data_en, 0);
    // Only plain storage words keep their value
    if (wr_addr < 13 && !(wr_addr inside {2, 4, 5, 6})) shadow[wr_addr] = wr_data;
  endtask

  task automatic start_read(input logic [31:0] rd_addr, input logic ready);
    int n;
    @(posedge clk_i);
    req_i.addr  <= rd_addr;
    req_i.data  <= '0;
    req_i.write <= 1'b0;
    req_valid_i <= 1'b1;
    rsp_ready_i <= ready;
    n = 0;
    @(negedge clk_i);
    while (!rsp_valid_o) begin
      if (n >= Timeout) report_timeout("rsp_valid_o");
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic do_read(input logic [31:0] rd_addr, input logic [31:0] mask,
                         input logic [31:0] exp_or);
    start_read(rd_addr, 1'b1);
    compare_values("rsp_data_o", rsp_data_o, (shadow_word(rd_addr) & mask) | exp_or);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  // Response held back for three cycles before the master takes it
  task automatic do_read_held(input logic [31:0] rd_addr, input logic [31:0] mask,
                              input logic [31:0] exp_or);
    logic [31:0] first;
    start_read(rd_addr, 1'b0);
    first = rsp_data_o;
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    for (int i = 0; i < 2; i++) begin
      @(negedge clk_i);
      compare_values("rsp_valid_o", rsp_valid_o, 1);
      compare_values("rsp_data_o", rsp_data_o, first);
      @(posedge clk_i);
      if (i == 1) rsp_ready_i <= 1'b1;
    end
    @(negedge clk_i);
    compare_values("rsp_valid_o", rsp_valid_o, 1);
    compare_values("rsp_data_o", rsp_data_o, (shadow_word(rd_addr) & mask) | exp_or);
    @(negedge clk_i);
    compare_values("rsp_valid_o", rsp_valid_o, 0);
  endtask

  task automatic wait_obs(input logic [3:0] exp);
    int n;
    n = 0;
    @(negedge clk_i);
    while (obs_o !== exp) begin
      if (n >= Timeout) report_timeout("obs_o state");
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic check_cfg();
    @(negedge clk_i);
    compare_values("core_cfg_o.seq_test", core_cfg_o.seq_test, shadow[0][2]);
    compare_values("core_cfg_o.port_a_sel", core_cfg_o.port_a_sel, shadow[0][4:3]);
    compare_values("core_cfg_o.port_b_sel", core_cfg_o.port_b_sel, shadow[0][5]);
    compare_values("core_cfg_o.am_num_pred", core_cfg_o.am_num_pred, shadow[1]);
    compare_values("core_cfg_o.inst_write_mode", core_cfg_o.inst_write_mode, shadow[3][0]);
    compare_values("core_cfg_o.inst_dbg", core_cfg_o.inst_dbg, shadow[3][1]);
    compare_values("loop_cfg_o.mode", loop_cfg_o.mode, shadow[7][2:0]);
    compare_values("loop_cfg_o.hvdim_sel", loop_cfg_o.hvdim_sel, shadow[7][4:3]);
    compare_values("loop_cfg_o.ext_count", loop_cfg_o.ext_count, shadow[7][9:5]);
    compare_values("loop_cfg_o.ext_en", loop_cfg_o.ext_en, shadow[7][9:5] != 0);
    compare_values("loop_cfg_o.jump_addr", loop_cfg_o.jump_addr, shadow[8]);
    compare_values("loop_cfg_o.end_addr", loop_cfg_o.end_addr, shadow[9]);
    compare_values("loop_cfg_o.count[1:0]", loop_cfg_o.count[1:0], shadow[10]);
    compare_values("loop_cfg_o.count[3:2]", loop_cfg_o.count[3:2], shadow[11]);
  endtask

  task automatic run_entry(input entry_t e);
    logic [31:0] w;
    case (e.op)
      OP_WR:       do_write(e.addr, e.data);
      OP_WR_RAND: begin
        draw_word(w);
        do_write(e.addr, w);
      end
      OP_RD:       do_read(e.addr, e.mask, e.exp);
      OP_RD_HOLD:  do_read_held(e.addr, e.mask, e.exp);
      OP_STATUS: begin
        @(posedge clk_i);
        busy_i          <= e.stat[17];
        am_pred_valid_i <= e.stat[16];
        am_pred_i       <= e.stat[15:8];
        inst_pc_i       <= e.stat[7:0];
      end
      OP_WAIT_OBS: wait_obs(e.exp[3:0]);
      default:     check_cfg();
    endcase
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    rst_ni          = 1'b0;
    req_i           = '0;
    req_valid_i     = 1'b0;
    rsp_ready_i     = 1'b1;
    busy_i          = 1'b0;
    am_pred_i       = '0;
    am_pred_valid_i = 1'b0;
    inst_pc_i       = '0;
    lfsr_q          = 16'd78;
    for (int i = 0; i < 13; i++) shadow[i] = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset state
    @(negedge clk_i);
    compare_values("pulse_o", pulse_o, 0);
    compare_values("inst_wr_o.addr_en", inst_wr_o.addr_en, 0);
    compare_values("inst_wr_o.data_en", inst_wr_o.data_en, 0);
    compare_values("rsp_valid_o", rsp_valid_o, 0);
    compare_values("obs_o", obs_o, 0);
    for (int a = 0; a < 13; a++) do_read(a, 0, 0);

    load_table();
    foreach (tbl[i]) run_entry(tbl[i]);

    $display("No errors");
    $finish;
  end

endmodule
